// ==== logic/uart_pkg.sv ====
`default_nettype none

package uart_pkg;

    typedef logic [7:0] uart_byte_t;              // One payload byte

    // Packed in wire order, so bit 0 leaves the line first
    typedef struct packed {
        logic       stop;                         // Always high
        uart_byte_t data;                         // Sent LSB first
        logic       start;                        // Always low
    } uart_frame_t;

    typedef logic [3:0] bit_idx_t;                // Bit position 0..9 inside a frame

    typedef enum logic {
        TX_IDLE = 1'b0,                           // Line high, waiting for a byte
        TX_SEND = 1'b1                            // Frame on the line
    } tx_state_t;

    localparam int FRAME_BITS = 10;               // Start + 8 data + stop

endpackage

`default_nettype wire

// ==== logic/baud_tick_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module baud_tick_gen #(
    parameter int BAUD_DIV = 8                    // Clocks per bit period
) (
    input  wire  clk,
    input  wire  rst,
    input  wire  restart,                         // Realign to a new frame
    output logic bit_tick                         // One cycle at each bit boundary
);

    localparam logic [15:0] RELOAD = 16'(BAUD_DIV - 1); // Terminal count of one period

    logic [15:0] cnt;                             // Cycles left in current bit

    assign bit_tick = (cnt == 16'd0);             // Last cycle of the bit period

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt <= RELOAD;
        end else if (restart) begin
            cnt <= RELOAD;                        // Frame start, full period follows
        end else if (bit_tick) begin
            cnt <= RELOAD;                        // Next bit period
        end else begin
            cnt <= cnt - 16'd1;
        end
    end

    // A tick is always followed by at least one quiet cycle unless the period is 1
    assert property (@(posedge clk) disable iff (rst)
        (BAUD_DIV > 1 && bit_tick) |=> !bit_tick)
        else $error("baud_tick_gen: bit_tick high on consecutive cycles");

endmodule

`default_nettype wire

// ==== logic/tx_fifo.sv ====
`timescale 1ns/10ps
`default_nettype none

module tx_fifo #(
    parameter int FIFO_DEPTH = 8                  // Power of two, at least 2
) (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  wr_en,           // Push strobe from host
    input  wire uart_pkg::uart_byte_t wr_data,
    input  wire                  rd_en,           // Pop strobe from shifter
    output uart_pkg::uart_byte_t rd_data,         // Head byte, valid while not empty
    output logic                 empty,
    output logic                 ready            // Room for at least one byte
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam logic [PTR_W:0] FULL_CNT = (PTR_W + 1)'(FIFO_DEPTH);

    uart_pkg::uart_byte_t mem [FIFO_DEPTH];       // Byte storage

    logic [PTR_W-1:0] head;                       // Next byte to send
    logic [PTR_W-1:0] tail;                       // Next free slot
    logic [PTR_W:0]   count;                      // Bytes held
    logic [PTR_W:0]   count_next;
    logic             push;
    logic             pop;

    assign push    = wr_en && ready;              // Writes while full are dropped
    assign pop     = rd_en && !empty;
    assign rd_data = mem[head];                   // Shown ahead of the pop

    // Occupancy update, push and pop together leave it unchanged
    always_comb begin
        count_next = count;
        case ({push, pop})
            2'b10:   count_next = count + 1'b1;
            2'b01:   count_next = count - 1'b1;
            default: count_next = count;
        endcase
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[tail] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            empty <= 1'b1;
            ready <= 1'b1;
        end else begin
            if (push) begin
                tail <= tail + 1'b1;              // Wraps at depth
            end
            if (pop) begin
                head <= head + 1'b1;              // Wraps at depth
            end
            count <= count_next;
            empty <= (count_next == '0);          // Flags follow the new count
            ready <= (count_next < FULL_CNT);
        end
    end

    // Shifter may only pop a byte that is there
    assert property (@(posedge clk) disable iff (rst)
        rd_en |-> !empty)
        else $error("tx_fifo: rd_en while empty");

    // Gated push keeps occupancy within the buffer
    assert property (@(posedge clk) disable iff (rst)
        count <= FULL_CNT)
        else $error("tx_fifo: count above FIFO_DEPTH");

endmodule

`default_nettype wire

// ==== logic/tx_shifter.sv ====
`timescale 1ns/10ps
`default_nettype none

module tx_shifter (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  empty,           // FIFO has no byte
    input  wire uart_pkg::uart_byte_t rd_data,    // FIFO head byte
    input  wire                  bit_tick,        // End of current bit period
    output logic                 rd_en,           // Pop pulse to FIFO
    output logic                 baud_restart,    // Realign bit timing
    output logic                 tx,              // Serial line
    output logic                 tx_busy
);

    localparam uart_pkg::bit_idx_t LAST_BIT = uart_pkg::bit_idx_t'(uart_pkg::FRAME_BITS - 1);

    uart_pkg::tx_state_t   state;
    uart_pkg::bit_idx_t    bit_idx;               // Bit now on the line
    uart_pkg::uart_frame_t load_frame;            // Frame built from head byte
    logic [uart_pkg::FRAME_BITS-1:0] shift_q;     // Bit 0 drives the line
    logic                  busy_q;
    logic                  last_tick;             // Stop bit has run its full period

    // Frame assembly around the head byte
    always_comb begin
        load_frame.start = 1'b0;
        load_frame.data  = rd_data;
        load_frame.stop  = 1'b1;
    end

    assign rd_en        = (state == uart_pkg::TX_IDLE) && !empty; // Pop only when idle
    assign baud_restart = rd_en;                  // Bit timing starts with the load
    assign last_tick    = bit_tick && (bit_idx == LAST_BIT);
    assign tx           = shift_q[0];
    assign tx_busy      = busy_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= uart_pkg::TX_IDLE;
            bit_idx <= '0;
            shift_q <= '1;                        // Line idles high
            busy_q  <= 1'b0;
        end else begin
            case (state)
                uart_pkg::TX_IDLE: begin
                    if (rd_en) begin
                        shift_q <= load_frame;    // Start bit goes out at once
                        bit_idx <= '0;
                        busy_q  <= 1'b1;
                        state   <= uart_pkg::TX_SEND;
                    end
                end
                uart_pkg::TX_SEND: begin
                    if (bit_tick) begin
                        shift_q <= {1'b1, shift_q[uart_pkg::FRAME_BITS-1:1]}; // High fill
                        if (last_tick) begin
                            state  <= uart_pkg::TX_IDLE;
                            busy_q <= !empty;     // Stay busy if another byte waits
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end
                end
                default: state <= uart_pkg::TX_IDLE;
            endcase
        end
    end

    // Start bit comes from the loaded frame
    assert property (@(posedge clk) disable iff (rst)
        (state == uart_pkg::TX_SEND && bit_idx == '0) |-> !tx)
        else $error("tx_shifter: start bit not low");

    // Stop bit survives nine shifts
    assert property (@(posedge clk) disable iff (rst)
        (state == uart_pkg::TX_SEND && bit_idx == LAST_BIT) |-> tx)
        else $error("tx_shifter: stop bit not high");

endmodule

`default_nettype wire

// ==== logic/uart_tx.sv ====
`timescale 1ns/10ps
`default_nettype none

module uart_tx #(
    parameter int CLK_FREQ_HZ = 27_000_000,       // System clock in Hz
    parameter int BAUD_RATE   = 115_200,          // Line rate in bits per second
    parameter int FIFO_DEPTH  = 8                 // Byte queue depth, power of two
) (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  wr_en,           // Host write pulse
    input  wire uart_pkg::uart_byte_t wr_data,    // Host byte
    output logic                 fifo_ready,      // Queue can take a byte
    output logic                 tx,              // Serial output
    output logic                 tx_busy          // Frame on the line
);

    localparam int BAUD_DIV = CLK_FREQ_HZ / BAUD_RATE; // Clocks per bit

    uart_pkg::uart_byte_t rd_data;                // Head byte to shifter
    logic                 rd_en;                  // Pop from shifter
    logic                 empty;
    logic                 baud_restart;           // Frame load realigns timing
    logic                 bit_tick;

    tx_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk     (clk),
        .rst     (rst),
        .wr_en   (wr_en),
        .wr_data (wr_data),
        .rd_en   (rd_en),
        .rd_data (rd_data),
        .empty   (empty),
        .ready   (fifo_ready)
    );

    baud_tick_gen #(
        .BAUD_DIV (BAUD_DIV)
    ) u_baud (
        .clk      (clk),
        .rst      (rst),
        .restart  (baud_restart),
        .bit_tick (bit_tick)
    );

    tx_shifter u_shifter (
        .clk          (clk),
        .rst          (rst),
        .empty        (empty),
        .rd_data      (rd_data),
        .bit_tick     (bit_tick),
        .rd_en        (rd_en),
        .baud_restart (baud_restart),
        .tx           (tx),
        .tx_busy      (tx_busy)
    );

endmodule

`default_nettype wire

// ==== verification/uart_tx_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module uart_tx_tb;

    localparam int CLK_FREQ_HZ = 10_000_000;      // 100 ns period
    localparam int BAUD_RATE   = 1_250_000;       // 8 clocks per bit
    localparam int FIFO_DEPTH  = 8;
    localparam int BAUD_DIV    = CLK_FREQ_HZ / BAUD_RATE;
    localparam int FRAME_CYC   = uart_pkg::FRAME_BITS * BAUD_DIV; // Clocks per frame
    localparam int NUM_TESTS   = 6;

    typedef struct packed {
        uart_pkg::uart_byte_t data;               // Used when not random
        logic [7:0]           burst;              // Writes on consecutive cycles
        logic                 wait_idle;          // Drain the line first
        logic                 rand_data;          // Bytes from the LFSR
        logic [7:0]           exp_drop;           // Writes refused while full
    } stim_t;

    string test_name [NUM_TESTS] = '{"single_a5", "single_3c", "burst_lfsr",
                                     "burst_append", "backpressure", "recovery"};
    // Columns are byte, burst, wait for idle, random, dropped writes
    stim_t stim [NUM_TESTS] = '{
        '{8'hA5, 8'd1,  1'b1, 1'b0, 8'd0},
        '{8'h3C, 8'd1,  1'b1, 1'b0, 8'd0},
        '{8'h00, 8'd4,  1'b1, 1'b1, 8'd0},
        '{8'h00, 8'd3,  1'b0, 1'b1, 8'd0},        // Lands behind a running burst
        '{8'h00, 8'd12, 1'b1, 1'b1, 8'd3},        // Eight queued plus one sending
        '{8'h5A, 8'd1,  1'b1, 1'b0, 8'd0}
    };

    logic                 clk;
    logic                 rst;
    logic                 wr_en;
    uart_pkg::uart_byte_t wr_data;
    logic                 fifo_ready;
    logic                 tx;
    logic                 tx_busy;

    uart_pkg::uart_byte_t model_q [$];            // Bytes the DUT accepted
    int                   owner_q [$];            // Test that wrote each byte
    logic [31:0]          lfsr_state = 32'h8237_5304;
    int                   cycle = 0;
    int                   wr_cycle = 0;           // First write after idle
    int                   chain_cycle = -1;       // Where a chained start bit is due
    string                chain_name = "";
    int                   dropped = 0;            // Writes refused in this test
    int                   mismatch_errors = 0;
    int                   other_errors = 0;
    logic                 expect_latency = 1'b0;
    logic                 decoding = 1'b0;
    logic                 line_prev = 1'b1;

    uart_tx #(
        .CLK_FREQ_HZ (CLK_FREQ_HZ),
        .BAUD_RATE   (BAUD_RATE),
        .FIFO_DEPTH  (FIFO_DEPTH)
    ) uut (
        .clk        (clk),
        .rst        (rst),
        .wr_en      (wr_en),
        .wr_data    (wr_data),
        .fifo_ready (fifo_ready),
        .tx         (tx),
        .tx_busy    (tx_busy)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1;     // Cycle index for latency checks

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic random_byte(output uart_pkg::uart_byte_t b);
        int n;
        b = '0;
        for (n = 0; n < 8; n++) begin
            lfsr_state = lfsr_next(lfsr_state);   // One step per bit
            b = {b[6:0], lfsr_state[0]};
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            mismatch_errors++;
            $display("mismatch %s: expected %b, actual %b", what, exp, act);
        end
    endtask

    task automatic check_byte(input string what, input uart_pkg::uart_byte_t exp,
                              input uart_pkg::uart_byte_t act);
        if (act !== exp) begin
            mismatch_errors++;
            $display("mismatch %s: expected 8'h%02h, actual 8'h%02h", what, exp, act);
        end
    endtask

    task automatic check_count(input string what, input int exp, input int act);
        if (act != exp) begin
            mismatch_errors++;
            $display("mismatch %s: expected %0d, actual %0d", what, exp, act);
        end
    endtask

    task automatic check_idle(input string what);
        check_bit({what, " tx"}, 1'b1, tx);
        check_bit({what, " tx_busy"}, 1'b0, tx_busy);
        check_bit({what, " fifo_ready"}, 1'b1, fifo_ready);
    endtask

    task automatic finish_run();
        $display("errors: %0d mismatch, %0d other", mismatch_errors, other_errors);
        if (mismatch_errors == 0 && other_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    endtask

    task automatic write_byte(input uart_pkg::uart_byte_t b, input int owner);
        @(posedge clk);
        #1;
        wr_en   = 1'b1;
        wr_data = b;
        if (fifo_ready) begin                     // Level the DUT sees at the next edge
            model_q.push_back(b);
            owner_q.push_back(owner);
        end else begin
            dropped++;
        end
    endtask

    // Returns once every accepted byte has been decoded off the line
    task automatic wait_idle();
        @(negedge clk);
        while (model_q.size() != 0 || decoding) begin
            @(negedge clk);
        end
        @(negedge clk);                           // Past the tick that ends the stop bit
    endtask

    // Entered at the first low cycle of a start bit
    task automatic decode_frame();
        uart_pkg::uart_frame_t           exp_frame;
        uart_pkg::uart_frame_t           got_frame;
        logic [uart_pkg::FRAME_BITS-1:0] exp_bits;
        logic [uart_pkg::FRAME_BITS-1:0] got_bits;
        uart_pkg::bit_idx_t              pos;
        string                           name;
        int                              k;
        decoding       = 1'b1;
        name           = "unexpected";
        exp_frame      = '1;
        exp_frame.start = 1'b0;
        if (model_q.size() == 0) begin
            other_errors++;
            $display("error: frame started on tx at cycle %0d with no byte written", cycle);
        end else begin
            exp_frame.data = model_q.pop_front();
            name = test_name[owner_q.pop_front()];
        end
        if (expect_latency) begin
            expect_latency = 1'b0;
            check_count({name, " write to start bit"}, 2, cycle - wr_cycle);
        end
        exp_bits = exp_frame;
        got_bits = '1;
        for (k = 0; k < FRAME_CYC; k++) begin
            if (k > 0) begin
                @(negedge clk);
            end
            pos = uart_pkg::bit_idx_t'(k / BAUD_DIV);
            check_bit($sformatf("%s tx bit %0d", name, pos), exp_bits[pos], tx);
            check_bit({name, " tx_busy in frame"}, 1'b1, tx_busy);
            if (k % BAUD_DIV == BAUD_DIV / 2) begin
                got_bits[pos] = tx;               // Centre sample
            end
        end
        got_frame = got_bits;
        if (!got_frame.stop) begin
            other_errors++;
            $display("error: %s frame has no stop bit, line low in bit 9", name);
        end
        check_byte({name, " data"}, exp_frame.data, got_frame.data);
        if (model_q.size() != 0) begin            // Queued byte means one high cycle first
            @(negedge clk);
            check_bit({name, " gap tx"}, 1'b1, tx);
            check_bit({name, " gap tx_busy"}, 1'b1, tx_busy);
            chain_cycle = cycle + 1;
            chain_name  = name;
        end
        decoding = 1'b0;
    endtask

    always begin
        @(negedge clk);
        if (cycle == chain_cycle) begin
            check_bit({chain_name, " chained start bit"}, 1'b0, tx);
        end
        if (!rst && line_prev && !tx) begin
            decode_frame();
        end
        line_prev = tx;
    end

    initial begin
        uart_pkg::uart_byte_t b;
        int t;
        int i;
        int burst_n;
        rst     = 1'b1;
        wr_en   = 1'b0;
        wr_data = '0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        repeat (20) begin
            @(negedge clk);
            check_idle("reset state");
        end
        for (t = 0; t < NUM_TESTS; t++) begin
            burst_n = int'(stim[t].burst);
            if (stim[t].wait_idle) begin
                wait_idle();
                check_idle({test_name[t], " before write"});
            end
            dropped = 0;
            for (i = 0; i < burst_n; i++) begin
                if (stim[t].rand_data) begin
                    random_byte(b);
                end else begin
                    b = stim[t].data;
                end
                write_byte(b, t);
                if (i == 0 && stim[t].wait_idle) begin
                    wr_cycle       = cycle;
                    expect_latency = 1'b1;
                end
            end
            @(posedge clk);
            #1;
            wr_en = 1'b0;
            check_count({test_name[t], " dropped writes"}, int'(stim[t].exp_drop), dropped);
        end
        wait_idle();
        check_idle("final drain");
        finish_run();
    end

    initial begin
        int limit;
        int t;
        limit = 200;
        for (t = 0; t < NUM_TESTS; t++) begin
            limit += int'(stim[t].burst) * FRAME_CYC;
        end
        while (cycle < limit) begin
            @(posedge clk);
        end
        other_errors++;
        $display("error: run did not finish within %0d cycles", limit);
        finish_run();
    end

endmodule

`default_nettype wire

// ==== compile.f ====
logic/uart_pkg.sv
logic/baud_tick_gen.sv
logic/tx_fifo.sv
logic/tx_shifter.sv
logic/uart_tx.sv
verification/uart_tx_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/10ps \
    -f compile.f --top-module uart_tx_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vuart_tx_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "ALL CHECKS PASSED" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1
